//--- msu_settings.svh
`ifndef MSU_SETTINGS_SVH
`define MSU_SETTINGS_SVH

// --------------------------------------------------
// data buffer
// --------------------------------------------------
`define MSU_BUF_ADDR_W 15
// last usable byte, trace pointer wraps after it
`define MSU_BUF_LAST 15'h77FF

// bytes written per trace record
`define TRACE_REC_BYTES 6

// id string "S-MSU1" at register offsets 2..7
`define MSU_ID0 8'h53
`define MSU_ID1 8'h2D
`define MSU_ID2 8'h4D
`define MSU_ID3 8'h53
`define MSU_ID4 8'h55
`define MSU_ID5 8'h31

// --------------------------------------------------
// trace config register file
// --------------------------------------------------
`define TRC_GROUP 8'h01
`define TRC_CFG_CONTROL 0
`define TRC_CFG_TRIGGER 1
// each match block is addr lo, mid, hi, then pa, data, control
`define TRC_CFG_MATCH0 2
`define TRC_CFG_MATCH1 8

`endif

//--- msu_pkg.sv
`include "msu_settings.svh"

package msu_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [23:0] bus_addr_t;
  typedef logic [`MSU_BUF_ADDR_W-1:0] buf_addr_t;

  // one bit per bus cycle type
  // bit 0 read, bit 1 write, bit 2 peripheral read, bit 3 peripheral write
  typedef logic [3:0] bus_kind_t;

  // console register offsets, named for read then write meaning
  typedef enum logic [2:0] {
    REG_STATUS_SEEK0 = 3'd0,
    REG_DATA_SEEK1   = 3'd1,
    REG_SEEK2        = 3'd2,
    REG_SEEK3        = 3'd3,
    REG_TRACK0       = 3'd4,
    REG_TRACK1       = 3'd5,
    REG_VOLUME       = 3'd6,
    REG_CONTROL      = 3'd7
  } msu_reg_t;

  // trace trigger fsm
  typedef enum logic [1:0] {
    TRACE_IDLE   = 2'd0,
    TRACE_ACTIVE = 2'd1,
    TRACE_DONE   = 2'd2
  } trace_state_t;

endpackage

//--- msu_regs.sv
`include "msu_settings.svh"

module msu_regs (
  input  logic               clkin,
  input  logic               reset,
  input  logic               enable,
  input  msu_pkg::msu_reg_t  reg_addr,
  input  msu_pkg::byte_t     reg_data_in,
  input  logic               reg_oe_falling,
  input  logic               reg_oe_rising,
  input  logic               reg_we_rising,
  input  logic [5:0]         status_reset_bits,
  input  logic [5:0]         status_set_bits,
  input  logic               status_reset_we,
  input  logic               msu_address_ext_write,
  input  msu_pkg::buf_addr_t msu_address_ext,
  input  msu_pkg::byte_t     msu_read_data,
  output msu_pkg::byte_t     reg_data_out,
  output msu_pkg::byte_t     status_out,
  output msu_pkg::byte_t     volume_out,
  output logic               volume_latch_out,
  output logic [31:0]        addr_out,
  output logic [15:0]        track_out,
  output msu_pkg::buf_addr_t msu_read_addr
);

  logic [1:0] status_we_sreg;
  logic       status_upd;
  logic [2:0] ext_wr_sreg;
  logic       ext_load;
  logic       reg_wr;
  logic       audio_start;
  logic       audio_busy;
  logic       data_start;
  logic       data_busy;
  logic       ctrl_start;
  logic       audio_error;
  logic [2:0] audio_ctrl;
  logic [1:0] audio_status;

  assign reg_wr = reg_we_rising && enable;

  // --------------------------------------------------
  // host side strobes, edge detect
  // --------------------------------------------------
  always_ff @(posedge clkin) begin
    if (reset) begin
      status_we_sreg <= 2'b00;
      ext_wr_sreg <= 3'b000;
    end else begin
      status_we_sreg <= {status_we_sreg[0], status_reset_we};
      ext_wr_sreg <= {ext_wr_sreg[1:0], msu_address_ext_write};
    end
  end

  // flag update 2 cycles after the rise
  assign status_upd = (status_we_sreg == 2'b01);
  // pointer load 3 cycles after the rise
  assign ext_load = (ext_wr_sreg[2:1] == 2'b01);

  // data read pointer
  always_ff @(posedge clkin) begin
    if (reset) begin
      msu_read_addr <= '0;
    end else if (ext_load) begin
      msu_read_addr <= msu_address_ext;
    end else if (reg_oe_rising && enable && reg_addr == msu_pkg::REG_DATA_SEEK1) begin
      // advance once the console has taken the byte
      msu_read_addr <= msu_read_addr + 1'b1;
    end
  end

  // --------------------------------------------------
  // register reads
  // --------------------------------------------------
  always_ff @(posedge clkin) begin
    if (reg_oe_falling && enable) begin
      case (reg_addr)
        msu_pkg::REG_STATUS_SEEK0:
          reg_data_out <= {data_busy, audio_busy, audio_status, audio_error, 3'b001};
        // buffer output already sits at the pointer
        msu_pkg::REG_DATA_SEEK1: reg_data_out <= msu_read_data;
        msu_pkg::REG_SEEK2:      reg_data_out <= `MSU_ID0;
        msu_pkg::REG_SEEK3:      reg_data_out <= `MSU_ID1;
        msu_pkg::REG_TRACK0:     reg_data_out <= `MSU_ID2;
        msu_pkg::REG_TRACK1:     reg_data_out <= `MSU_ID3;
        msu_pkg::REG_VOLUME:     reg_data_out <= `MSU_ID4;
        default:                 reg_data_out <= `MSU_ID5;
      endcase
    end
  end

  // --------------------------------------------------
  // register writes, seek / track / volume fields
  // --------------------------------------------------
  always_ff @(posedge clkin) begin
    if (reg_wr) begin
      case (reg_addr)
        msu_pkg::REG_STATUS_SEEK0: addr_out[7:0] <= reg_data_in;
        msu_pkg::REG_DATA_SEEK1:   addr_out[15:8] <= reg_data_in;
        msu_pkg::REG_SEEK2:        addr_out[23:16] <= reg_data_in;
        msu_pkg::REG_SEEK3:        addr_out[31:24] <= reg_data_in;
        msu_pkg::REG_TRACK0:       track_out[7:0] <= reg_data_in;
        msu_pkg::REG_TRACK1:       track_out[15:8] <= reg_data_in;
        msu_pkg::REG_VOLUME:       volume_out <= reg_data_in;
        default: ;
      endcase
    end
  end

  // start / busy flags
  always_ff @(posedge clkin) begin
    if (reset) begin
      audio_busy <= 1'b1;
      data_busy <= 1'b1;
      audio_start <= 1'b0;
      data_start <= 1'b0;
      ctrl_start <= 1'b0;
      audio_error <= 1'b0;
      audio_ctrl <= 3'b000;
      audio_status <= 2'b00;
      volume_latch_out <= 1'b0;
    end else begin
      volume_latch_out <= reg_wr && (reg_addr == msu_pkg::REG_VOLUME);
      if (reg_wr) begin
        case (reg_addr)
          // top seek byte kicks off the data side
          msu_pkg::REG_SEEK3: begin
            data_start <= 1'b1;
            data_busy <= 1'b1;
          end
          msu_pkg::REG_TRACK1: begin
            audio_start <= 1'b1;
            audio_busy <= 1'b1;
          end
          // control ignored while a track is still loading
          msu_pkg::REG_CONTROL: begin
            if (!audio_busy) begin
              audio_ctrl <= reg_data_in[2:0];
              ctrl_start <= 1'b1;
            end
          end
          default: ;
        endcase
      end else if (status_upd) begin
        // clear beats set on every bit
        audio_busy <= (audio_busy | status_set_bits[5]) & ~status_reset_bits[5];
        data_busy <= (data_busy | status_set_bits[4]) & ~status_reset_bits[4];
        if (status_reset_bits[5]) begin
          audio_start <= 1'b0;
        end
        if (status_reset_bits[4]) begin
          data_start <= 1'b0;
        end
        audio_error <= (audio_error | status_set_bits[3]) & ~status_reset_bits[3];
        audio_status <= (audio_status | status_set_bits[2:1]) & ~status_reset_bits[2:1];
        ctrl_start <= (ctrl_start | status_set_bits[0]) & ~status_reset_bits[0];
      end
    end
  end

  assign status_out = {msu_read_addr[13], audio_start, data_start, volume_latch_out,
                       audio_ctrl, ctrl_start};

  // volume latch is a single cycle pulse toward the audio side
  a_volume_pulse: assert property (@(posedge clkin) disable iff (reset)
    volume_latch_out |=> !volume_latch_out);

endmodule

//--- msu_databuf.sv
`include "msu_settings.svh"

module msu_databuf (
  input  logic               clkin,
  input  logic               feature_enable,
  input  logic               pgm_we,
  input  msu_pkg::buf_addr_t pgm_address,
  input  msu_pkg::byte_t     pgm_data,
  input  logic               trace_we,
  input  msu_pkg::buf_addr_t trace_addr,
  input  msu_pkg::byte_t     trace_data,
  input  msu_pkg::buf_addr_t msu_read_addr,
  output msu_pkg::byte_t     msu_read_data,
  output msu_pkg::byte_t     msu_data_out
);

  localparam int DEPTH = 1 << `MSU_BUF_ADDR_W;

  msu_pkg::byte_t     mem [0:DEPTH-1];
  logic               wr_en;
  msu_pkg::buf_addr_t wr_addr;
  msu_pkg::byte_t     wr_data;
  msu_pkg::buf_addr_t rd_addr;
  msu_pkg::byte_t     rd_data;

  // msu mode: host fills, msu reads
  // trace mode: recorder fills, host reads back
  always_comb begin
    wr_en = feature_enable ? ~pgm_we : trace_we;
    wr_addr = feature_enable ? pgm_address : trace_addr;
    wr_data = feature_enable ? pgm_data : trace_data;
    rd_addr = feature_enable ? msu_read_addr : pgm_address;
  end

  // simple dual port, registered read
  always_ff @(posedge clkin) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    rd_data <= mem[rd_addr];
  end

  assign msu_read_data = rd_data;
  assign msu_data_out = rd_data;

endmodule

//--- trace_match.sv
module trace_match (
  input  logic               clkin,
  input  logic               clear,
  input  msu_pkg::bus_addr_t bus_addr,
  input  msu_pkg::byte_t     bus_pa,
  input  msu_pkg::byte_t     bus_data,
  input  msu_pkg::bus_addr_t match_addr,
  input  msu_pkg::byte_t     match_pa,
  input  msu_pkg::byte_t     match_data,
  input  logic [4:0]         match_control,
  input  msu_pkg::bus_kind_t trans_mask,
  output logic               hit
);

  msu_pkg::bus_kind_t kinds;
  logic addr_eq;
  logic pa_eq;
  logic data_eq;
  logic addr_ok;
  logic pa_ok;
  logic data_ok;
  logic mask_ok;

  // enabled cycle kinds, bit 4 is the data compare enable
  assign kinds = match_control[3:0];

  // stage 1, raw compares
  always_ff @(posedge clkin) begin
    if (clear) begin
      addr_eq <= 1'b0;
      pa_eq <= 1'b0;
      data_eq <= 1'b0;
    end else begin
      addr_eq <= (bus_addr == match_addr);
      pa_eq <= (bus_pa == match_pa);
      data_eq <= (bus_data == match_data);
    end
  end

  // a field only matters when its cycle kind is enabled
  assign addr_ok = ~(kinds[0] | kinds[1]) | addr_eq;
  assign pa_ok = ~(kinds[2] | kinds[3]) | pa_eq;
  assign data_ok = ~match_control[4] | data_eq;
  // every enabled kind must be present in the transaction
  assign mask_ok = &(~kinds | trans_mask);

  // stage 2, qualified hit
  always_ff @(posedge clkin) begin
    if (clear) begin
      hit <= 1'b0;
    end else begin
      hit <= addr_ok & pa_ok & data_ok & mask_ok;
    end
  end

endmodule

//--- trace_capture.sv
`include "msu_settings.svh"

module trace_capture (
  input  logic               clkin,
  input  logic               reset,
  input  msu_pkg::bus_kind_t bus_start,
  input  msu_pkg::bus_kind_t bus_end,
  input  msu_pkg::bus_kind_t bus_strobe_n,
  input  logic               romsel_n,
  input  msu_pkg::bus_addr_t bus_addr,
  input  msu_pkg::byte_t     bus_pa,
  input  msu_pkg::byte_t     bus_data,
  input  msu_pkg::byte_t     cfg_group,
  input  msu_pkg::byte_t     cfg_index,
  input  msu_pkg::byte_t     cfg_value,
  input  msu_pkg::byte_t     cfg_invmask,
  input  logic               cfg_we,
  input  msu_pkg::byte_t     cfg_read,
  output msu_pkg::byte_t     cfg_data_out,
  output logic               trace_enable,
  output logic               trace_we,
  output msu_pkg::buf_addr_t trace_addr,
  output msu_pkg::byte_t     trace_data
);

  localparam int M0 = `TRC_CFG_MATCH0;
  localparam int M1 = `TRC_CFG_MATCH1;
  localparam int REC_W = `TRACE_REC_BYTES * 8;

  msu_pkg::byte_t        cfg_r [0:15];
  msu_pkg::byte_t        trig;
  logic                  multishot;
  logic                  match_clear;
  logic                  match0_hit;
  logic                  match1_hit;
  logic                  start_hit;
  logic                  stop_hit;
  msu_pkg::trace_state_t state;
  msu_pkg::bus_addr_t    addr_r;
  msu_pkg::bus_kind_t    mask;
  logic [4:0]            control;
  logic [REC_W-1:0]      rec;
  logic [2:0]            count;
  msu_pkg::buf_addr_t    wr_addr;
  logic                  full_r;
  logic                  stop_armed;
  logic                  trans_end;
  logic                  last_byte;
  logic                  we_in;

  // --------------------------------------------------
  // config register file with masked read-modify-write
  // --------------------------------------------------
  always_ff @(posedge clkin) begin
    if (reset) begin
      for (int i = 0; i < 16; i++) begin
        cfg_r[i] <= '0;
      end
    end else if (cfg_we && cfg_group == `TRC_GROUP && cfg_index[7:4] == 4'h0) begin
      // invmask bits keep the old value
      cfg_r[cfg_index[3:0]] <= (cfg_r[cfg_index[3:0]] & cfg_invmask) |
                               (cfg_value & ~cfg_invmask);
    end
  end

  assign trace_enable = cfg_r[`TRC_CFG_CONTROL][0];
  assign multishot = cfg_r[`TRC_CFG_CONTROL][2];
  assign trig = cfg_r[`TRC_CFG_TRIGGER];

  // index 0 reads back live status
  always_comb begin
    if (cfg_read == 8'h00) begin
      cfg_data_out = {2'b00, full_r, start_hit, stop_armed, stop_hit, state};
    end else if (cfg_read[7:4] != 4'h0) begin
      cfg_data_out = '0;
    end else begin
      cfg_data_out = cfg_r[cfg_read[3:0]];
    end
  end

  // --------------------------------------------------
  // match units
  // --------------------------------------------------
  always_ff @(posedge clkin) begin
    addr_r <= bus_addr;
  end

  assign match_clear = reset | ~trace_enable;

  trace_match match0 (
    .clkin         (clkin),
    .clear         (match_clear),
    .bus_addr      (addr_r),
    .bus_pa        (bus_pa),
    .bus_data      (bus_data),
    .match_addr    ({cfg_r[M0+2], cfg_r[M0+1], cfg_r[M0]}),
    .match_pa      (cfg_r[M0+3]),
    .match_data    (cfg_r[M0+4]),
    .match_control (cfg_r[M0+5][4:0]),
    .trans_mask    (mask),
    .hit           (match0_hit)
  );

  trace_match match1 (
    .clkin         (clkin),
    .clear         (match_clear),
    .bus_addr      (addr_r),
    .bus_pa        (bus_pa),
    .bus_data      (bus_data),
    .match_addr    ({cfg_r[M1+2], cfg_r[M1+1], cfg_r[M1]}),
    .match_pa      (cfg_r[M1+3]),
    .match_data    (cfg_r[M1+4]),
    .match_control (cfg_r[M1+5][4:0]),
    .trans_mask    (mask),
    .hit           (match1_hit)
  );

  // no start bits set means record from the first transaction
  assign start_hit = (trig[3:0] == 4'h0) | (trig[0] & match0_hit) | (trig[1] & match1_hit);
  assign stop_hit = (trig[4] & match0_hit) | (trig[5] & match1_hit) | (trig[6] & full_r);

  // --------------------------------------------------
  // capture and trigger fsm
  // --------------------------------------------------
  assign trans_end = |(mask & bus_end);
  assign last_byte = (wr_addr == `MSU_BUF_LAST);
  // stop-on-full also blocks further writes
  assign we_in = (state == msu_pkg::TRACE_ACTIVE) && (count != 3'd0) && (!trig[6] || !full_r);

  always_ff @(posedge clkin) begin
    if (reset || !trace_enable) begin
      state <= msu_pkg::TRACE_IDLE;
      count <= 3'd0;
      wr_addr <= '0;
      full_r <= 1'b0;
      mask <= '0;
      control <= '0;
      stop_armed <= 1'b0;
    end else begin
      full_r <= full_r | (last_byte & we_in);
      if (count != 3'd0) begin
        // drain the record one byte per cycle
        count <= (count == `TRACE_REC_BYTES) ? 3'd0 : count + 3'd1;
        wr_addr <= last_byte ? '0 : wr_addr + 1'b1;
      end else if (mask == '0) begin
        // first start strobe opens the transaction
        mask <= bus_start;
      end else if (trans_end) begin
        count <= 3'd1;
        mask <= '0;
        control <= '0;
        if ((state == msu_pkg::TRACE_IDLE || (state == msu_pkg::TRACE_DONE && multishot))
            && start_hit) begin
          wr_addr <= '0;
          full_r <= 1'b0;
          stop_armed <= 1'b0;
          state <= msu_pkg::TRACE_ACTIVE;
        end else if (stop_armed && state == msu_pkg::TRACE_ACTIVE) begin
          state <= msu_pkg::TRACE_DONE;
        end else if (stop_hit) begin
          // stop takes effect on the following transaction
          stop_armed <= 1'b1;
        end
      end else begin
        // accumulate cycle kinds seen from the active low strobes
        control <= control | {~romsel_n, ~bus_strobe_n};
      end
    end
  end

  // record shifter sends the control byte first
  always_ff @(posedge clkin) begin
    if (count == 3'd0 && trans_end) begin
      rec <= {bus_pa, addr_r, bus_data, 3'b000, control};
    end else if (count != 3'd0) begin
      rec <= rec >> 8;
    end
  end

  // buffer write port
  always_ff @(posedge clkin) begin
    if (reset) begin
      trace_we <= 1'b0;
    end else begin
      trace_we <= we_in;
    end
  end

  always_ff @(posedge clkin) begin
    trace_addr <= wr_addr;
    trace_data <= rec[7:0];
  end

  // trace pointer never runs past the last buffer byte
  a_addr_in_range: assert property (@(posedge clkin) disable iff (reset)
    wr_addr <= `MSU_BUF_LAST);

endmodule

//--- msu_top.sv
module msu_top (
  input  logic               clkin,
  input  logic               reset,
  input  logic               enable,
  input  logic               feature_enable,
  // host program port
  input  logic               pgm_we,
  input  msu_pkg::buf_addr_t pgm_address,
  input  msu_pkg::byte_t     pgm_data,
  // console register port
  input  msu_pkg::msu_reg_t  reg_addr,
  input  msu_pkg::byte_t     reg_data_in,
  input  logic               reg_oe_falling,
  input  logic               reg_oe_rising,
  input  logic               reg_we_rising,
  input  logic [5:0]         status_reset_bits,
  input  logic [5:0]         status_set_bits,
  input  logic               status_reset_we,
  input  logic               msu_address_ext_write,
  input  msu_pkg::buf_addr_t msu_address_ext,
  // snes bus
  input  msu_pkg::bus_addr_t snes_addr,
  input  msu_pkg::byte_t     snes_pa,
  input  msu_pkg::byte_t     snes_data,
  input  logic               snes_rd_start, snes_wr_start, snes_pard_start, snes_pawr_start,
  input  logic               snes_rd_end, snes_wr_end, snes_pard_end, snes_pawr_end,
  input  logic               snes_rd, snes_wr, snes_pard, snes_pawr,
  input  logic               snes_romsel,
  // trace config port
  input  msu_pkg::byte_t     cfg_group,
  input  msu_pkg::byte_t     cfg_index,
  input  msu_pkg::byte_t     cfg_value,
  input  msu_pkg::byte_t     cfg_invmask,
  input  logic               cfg_we,
  input  msu_pkg::byte_t     cfg_read,
  output msu_pkg::byte_t     reg_data_out,
  output msu_pkg::byte_t     status_out,
  output msu_pkg::byte_t     volume_out,
  output logic               volume_latch_out,
  output logic [31:0]        addr_out,
  output logic [15:0]        track_out,
  output msu_pkg::byte_t     msu_data_out,
  output msu_pkg::byte_t     trc_config_data_out
);

  msu_pkg::buf_addr_t msu_read_addr;
  msu_pkg::byte_t     msu_read_data;
  logic               trace_we;
  msu_pkg::buf_addr_t trace_addr;
  msu_pkg::byte_t     trace_data;

  // port names line up with the top level
  msu_regs u_regs (.*);

  msu_databuf u_databuf (.*);

  // bus kinds packed as pawr, pard, wr, rd
  trace_capture u_trace (
    .clkin        (clkin),
    .reset        (reset),
    .bus_start    ({snes_pawr_start, snes_pard_start, snes_wr_start, snes_rd_start}),
    .bus_end      ({snes_pawr_end, snes_pard_end, snes_wr_end, snes_rd_end}),
    .bus_strobe_n ({snes_pawr, snes_pard, snes_wr, snes_rd}),
    .romsel_n     (snes_romsel),
    .bus_addr     (snes_addr),
    .bus_pa       (snes_pa),
    .bus_data     (snes_data),
    .cfg_group    (cfg_group),
    .cfg_index    (cfg_index),
    .cfg_value    (cfg_value),
    .cfg_invmask  (cfg_invmask),
    .cfg_we       (cfg_we),
    .cfg_read     (cfg_read),
    .cfg_data_out (trc_config_data_out),
    .trace_enable (),
    .trace_we     (trace_we),
    .trace_addr   (trace_addr),
    .trace_data   (trace_data)
  );

endmodule

//--- msu_tb.sv
`include "msu_settings.svh"

module msu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // tests need well under 1500 cycles
  localparam int MAX_CYCLES = 4000;

  logic clkin;
  logic reset;
  logic enable;
  logic feature_enable;
  logic pgm_we;
  msu_pkg::buf_addr_t pgm_address;
  msu_pkg::byte_t pgm_data;
  msu_pkg::msu_reg_t reg_addr;
  msu_pkg::byte_t reg_data_in;
  logic reg_oe_falling;
  logic reg_oe_rising;
  logic reg_we_rising;
  logic [5:0] status_reset_bits;
  logic [5:0] status_set_bits;
  logic status_reset_we;
  logic msu_address_ext_write;
  msu_pkg::buf_addr_t msu_address_ext;
  msu_pkg::bus_addr_t snes_addr;
  msu_pkg::byte_t snes_pa;
  msu_pkg::byte_t snes_data;
  logic snes_rd_start, snes_wr_start, snes_pard_start, snes_pawr_start;
  logic snes_rd_end, snes_wr_end, snes_pard_end, snes_pawr_end;
  logic snes_rd, snes_wr, snes_pard, snes_pawr;
  logic snes_romsel;
  msu_pkg::byte_t cfg_group;
  msu_pkg::byte_t cfg_index;
  msu_pkg::byte_t cfg_value;
  msu_pkg::byte_t cfg_invmask;
  logic cfg_we;
  msu_pkg::byte_t cfg_read;
  msu_pkg::byte_t reg_data_out;
  msu_pkg::byte_t status_out;
  msu_pkg::byte_t volume_out;
  logic volume_latch_out;
  logic [31:0] addr_out;
  logic [15:0] track_out;
  msu_pkg::byte_t msu_data_out;
  msu_pkg::byte_t trc_config_data_out;

  integer seed = 21;
  int cycle_count = 0;

  msu_top dut (.*);

  always #4 clkin = ~clkin;

  // --------------------------------------------------
  // failure reporting and compare tasks
  // --------------------------------------------------
  task automatic stop_on_failure();
    $display("Simulation FAILED");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check_byte(input string name, input msu_pkg::byte_t got,
                            input msu_pkg::byte_t exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_state(input string name, input msu_pkg::trace_state_t got,
                             input msu_pkg::trace_state_t exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s = %s, expected %s", $time, name, got.name(),
               exp.name());
      stop_on_failure();
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  // hard stop on a hung sequence
  always @(posedge clkin) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
      stop_on_failure();
    end
  end

  // --------------------------------------------------
  // bus drivers
  // --------------------------------------------------
  // falling strobe latches the byte, rising strobe advances the data pointer
  task automatic reg_read(input msu_pkg::msu_reg_t a, output msu_pkg::byte_t d);
    @(posedge clkin);
    reg_addr <= a;
    reg_oe_falling <= 1'b1;
    @(posedge clkin);
    reg_oe_falling <= 1'b0;
    reg_oe_rising <= 1'b1;
    @(negedge clkin);
    d = reg_data_out;
    @(posedge clkin);
    reg_oe_rising <= 1'b0;
  endtask

  task automatic reg_write(input msu_pkg::msu_reg_t a, input msu_pkg::byte_t d);
    @(posedge clkin);
    reg_addr <= a;
    reg_data_in <= d;
    reg_we_rising <= 1'b1;
    @(posedge clkin);
    reg_we_rising <= 1'b0;
  endtask

  // pgm_we is active low, held across back to back bytes
  task automatic pgm_write(input msu_pkg::buf_addr_t a, input msu_pkg::byte_t d);
    @(posedge clkin);
    pgm_address <= a;
    pgm_data <= d;
    pgm_we <= 1'b0;
  endtask

  // host readback, one cycle ram latency
  task automatic buf_read(input msu_pkg::buf_addr_t a, output msu_pkg::byte_t d);
    @(posedge clkin);
    pgm_address <= a;
    @(posedge clkin);
    @(negedge clkin);
    d = msu_data_out;
  endtask

  task automatic cfg_write(input msu_pkg::byte_t idx, input msu_pkg::byte_t val);
    @(posedge clkin);
    cfg_group <= `TRC_GROUP;
    cfg_index <= idx;
    cfg_value <= val;
    cfg_invmask <= 8'h00;
    cfg_we <= 1'b1;
    @(posedge clkin);
    cfg_we <= 1'b0;
  endtask

  task automatic trace_status(output msu_pkg::byte_t s);
    @(posedge clkin);
    cfg_read <= 8'h00;
    @(negedge clkin);
    s = trc_config_data_out;
  endtask

  // start pulse, live strobe low 3 cycles, end pulse, then record drain
  task automatic bus_transaction(input msu_pkg::bus_kind_t kind, input msu_pkg::bus_addr_t a,
                                 input msu_pkg::byte_t pa, input msu_pkg::byte_t d,
                                 input logic rom);
    @(posedge clkin);
    snes_addr <= a;
    snes_pa <= pa;
    snes_data <= d;
    snes_romsel <= ~rom;
    {snes_pawr_start, snes_pard_start, snes_wr_start, snes_rd_start} <= kind;
    {snes_pawr, snes_pard, snes_wr, snes_rd} <= ~kind;
    @(posedge clkin);
    {snes_pawr_start, snes_pard_start, snes_wr_start, snes_rd_start} <= 4'h0;
    repeat (2) @(posedge clkin);
    {snes_pawr, snes_pard, snes_wr, snes_rd} <= 4'hF;
    snes_romsel <= 1'b1;
    {snes_pawr_end, snes_pard_end, snes_wr_end, snes_rd_end} <= kind;
    @(posedge clkin);
    {snes_pawr_end, snes_pard_end, snes_wr_end, snes_rd_end} <= 4'h0;
    repeat (8) @(posedge clkin);
  endtask

  // --------------------------------------------------
  // directed tests
  // --------------------------------------------------
  task automatic id_and_status_reads();
    msu_pkg::byte_t d;
    msu_pkg::byte_t id_bytes [6];
    id_bytes = '{`MSU_ID0, `MSU_ID1, `MSU_ID2, `MSU_ID3, `MSU_ID4, `MSU_ID5};
    // both busy after reset
    reg_read(msu_pkg::REG_STATUS_SEEK0, d);
    check_byte("status read", d, 8'hC1);
    for (int i = 0; i < 6; i++) begin
      reg_read(msu_pkg::msu_reg_t'(i + 2), d);
      check_byte($sformatf("id byte %0d", i), d, id_bytes[i]);
    end
  endtask

  task automatic seek_track_volume_writes();
    logic [31:0] seek;
    logic [15:0] track;
    msu_pkg::byte_t vol;
    int high_cycles;
    seek = $random(seed);
    track = $random(seed);
    vol = $random(seed);
    high_cycles = 0;
    reg_write(msu_pkg::REG_STATUS_SEEK0, seek[7:0]);
    reg_write(msu_pkg::REG_DATA_SEEK1, seek[15:8]);
    reg_write(msu_pkg::REG_SEEK2, seek[23:16]);
    reg_write(msu_pkg::REG_SEEK3, seek[31:24]);
    @(negedge clkin);
    check_word("addr_out", addr_out, seek);
    check_byte("status_out[5] data start", {7'd0, status_out[5]}, 8'h01);
    reg_write(msu_pkg::REG_TRACK0, track[7:0]);
    reg_write(msu_pkg::REG_TRACK1, track[15:8]);
    @(negedge clkin);
    check_word("track_out", {16'h0000, track_out}, {16'h0000, track});
    check_byte("status_out[6] audio start", {7'd0, status_out[6]}, 8'h01);
    reg_write(msu_pkg::REG_VOLUME, vol);
    // count latch pulse width over a short window
    repeat (4) begin
      @(negedge clkin);
      if (volume_latch_out) begin
        high_cycles++;
      end
    end
    check_byte("volume_out", volume_out, vol);
    check_byte("volume_latch_out high cycles", 8'(high_cycles), 8'd1);
  endtask

  task automatic data_port_reads();
    msu_pkg::buf_addr_t base;
    msu_pkg::byte_t fill [8];
    msu_pkg::byte_t d;
    base = 15'h0120;
    @(posedge clkin);
    feature_enable <= 1'b1;
    for (int i = 0; i < 8; i++) begin
      fill[i] = $random(seed);
      pgm_write(base + 15'(i), fill[i]);
    end
    @(posedge clkin);
    pgm_we <= 1'b1;
    // pointer loads 3 cycles after the rise
    msu_address_ext <= base;
    msu_address_ext_write <= 1'b1;
    repeat (3) @(posedge clkin);
    msu_address_ext_write <= 1'b0;
    @(posedge clkin);
    for (int i = 0; i < 8; i++) begin
      reg_read(msu_pkg::REG_DATA_SEEK1, d);
      check_byte($sformatf("data port byte %0d", i), d, fill[i]);
    end
  endtask

  task automatic busy_flag_clear();
    msu_pkg::byte_t d;
    @(posedge clkin);
    status_reset_bits <= 6'b110000;
    status_set_bits <= 6'b000000;
    status_reset_we <= 1'b1;
    @(posedge clkin);
    status_reset_we <= 1'b0;
    repeat (3) @(posedge clkin);
    reg_read(msu_pkg::REG_STATUS_SEEK0, d);
    check_byte("status read after clear", d, 8'h01);
    @(negedge clkin);
    check_byte("status_out[6:5]", {6'd0, status_out[6:5]}, 8'h00);
  endtask

  task automatic trace_record_capture();
    msu_pkg::byte_t exp [6];
    msu_pkg::byte_t d;
    // write + rom select, data, addr lo, mid, hi, pa
    exp = '{8'h12, 8'hA5, 8'h34, 8'h56, 8'h7E, 8'h18};
    @(posedge clkin);
    feature_enable <= 1'b0;
    cfg_write(`TRC_CFG_TRIGGER, 8'h00);
    cfg_write(`TRC_CFG_CONTROL, 8'h01);
    bus_transaction(4'b0010, 24'h7E5634, 8'h18, 8'hA5, 1'b1);
    for (int i = 0; i < 6; i++) begin
      buf_read(15'(i), d);
      check_byte($sformatf("trace record byte %0d", i), d, exp[i]);
    end
    trace_status(d);
    check_state("trace state", msu_pkg::trace_state_t'(d[1:0]), msu_pkg::TRACE_ACTIVE);
  endtask

  task automatic trace_trigger_sequence();
    msu_pkg::byte_t s;
    // disable returns the fsm to idle
    cfg_write(`TRC_CFG_CONTROL, 8'h00);
    cfg_write(`TRC_CFG_MATCH0, 8'hCD);
    cfg_write(`TRC_CFG_MATCH0 + 1, 8'hAB);
    cfg_write(`TRC_CFG_MATCH0 + 2, 8'h00);
    cfg_write(`TRC_CFG_MATCH0 + 3, 8'h00);
    cfg_write(`TRC_CFG_MATCH0 + 4, 8'h00);
    // match on write cycles only
    cfg_write(`TRC_CFG_MATCH0 + 5, 8'h02);
    // start on match0, stop on match0
    cfg_write(`TRC_CFG_TRIGGER, 8'h11);
    cfg_write(`TRC_CFG_CONTROL, 8'h01);
    bus_transaction(4'b0010, 24'h00ABCE, 8'h00, 8'h11, 1'b0);
    trace_status(s);
    check_state("state after miss", msu_pkg::trace_state_t'(s[1:0]), msu_pkg::TRACE_IDLE);
    bus_transaction(4'b0010, 24'h00ABCD, 8'h00, 8'h22, 1'b0);
    trace_status(s);
    check_state("state after start", msu_pkg::trace_state_t'(s[1:0]), msu_pkg::TRACE_ACTIVE);
    bus_transaction(4'b0010, 24'h00ABCD, 8'h00, 8'h33, 1'b0);
    trace_status(s);
    check_state("state after stop match", msu_pkg::trace_state_t'(s[1:0]),
                msu_pkg::TRACE_ACTIVE);
    check_byte("stop armed", {7'd0, s[3]}, 8'h01);
    bus_transaction(4'b0010, 24'h001000, 8'h00, 8'h44, 1'b0);
    trace_status(s);
    check_state("state after stop", msu_pkg::trace_state_t'(s[1:0]), msu_pkg::TRACE_DONE);
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    clkin = 1'b0;
    reset = 1'b1;
    enable = 1'b1;
    feature_enable = 1'b0;
    pgm_we = 1'b1;
    pgm_address = '0;
    pgm_data = '0;
    reg_addr = msu_pkg::REG_STATUS_SEEK0;
    reg_data_in = '0;
    reg_oe_falling = 1'b0;
    reg_oe_rising = 1'b0;
    reg_we_rising = 1'b0;
    status_reset_bits = '0;
    status_set_bits = '0;
    status_reset_we = 1'b0;
    msu_address_ext_write = 1'b0;
    msu_address_ext = '0;
    snes_addr = '0;
    snes_pa = '0;
    snes_data = '0;
    {snes_rd_start, snes_wr_start, snes_pard_start, snes_pawr_start} = 4'h0;
    {snes_rd_end, snes_wr_end, snes_pard_end, snes_pawr_end} = 4'h0;
    // live strobes and rom select idle high
    {snes_rd, snes_wr, snes_pard, snes_pawr} = 4'hF;
    snes_romsel = 1'b1;
    cfg_group = '0;
    cfg_index = '0;
    cfg_value = '0;
    cfg_invmask = '0;
    cfg_we = 1'b0;
    cfg_read = '0;
    repeat (3) @(posedge clkin);
    reset <= 1'b0;
    repeat (2) @(posedge clkin);
    id_and_status_reads();
    seek_track_volume_writes();
    data_port_reads();
    busy_flag_clear();
    trace_record_capture();
    trace_trigger_sequence();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- msu.f
+incdir+.
msu_pkg.sv
msu_regs.sv
msu_databuf.sv
trace_match.sv
trace_capture.sv
msu_top.sv
msu_tb.sv

//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := msu_tb
FILELIST := msu.f

SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST))) msu_settings.svh
BIN  := obj_dir/V$(TOP)
LOG  := sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
